// File: sim.f
+incdir+source
source/ps_cpld_pkg.sv
source/ctrlport_decoder.sv
source/board_ctrl_regs.sv
source/ctrlport_responder.sv
source/ps_cpld_regs.sv
bench/tb_ps_cpld_regs.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_ps_cpld_regs -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
  exit 0
fi
exit 1

// File: bench/tb_ps_cpld_regs.sv
/* ps cpld register testbench */

`timescale 1ns/1ns

`include "ps_cpld_cfg.svh"

module tb_ps_cpld_regs;

  import ps_cpld_pkg::*;

  localparam logic [19:0] base = `PS_CPLD_BASE_ADDR;

  logic        ctrlport_clk;
  logic        ctrlport_rst;
  logic        req_wr;
  logic        req_rd;
  logic [19:0] req_addr;
  logic [31:0] req_data;
  logic        cmi_other_side_detected;
  logic        resp_ack;
  logic [1:0]  resp_status;
  logic [31:0] resp_data;
  logic [1:0]  db_clk_enable;
  logic [1:0]  db_reset;
  logic        pll_ref_clk_enable;
  logic [11:0] dio_direction_a;
  logic [11:0] dio_direction_b;
  logic        cmi_ready;

  // register model
  logic [31:0] m_scratch;
  logic [1:0]  m_clk_en;
  logic [1:0]  m_rst;
  logic        m_pll;
  logic [11:0] m_dio_a;
  logic [11:0] m_dio_b;
  logic        m_cmi_ready;
  logic        m_other;

  logic [31:0] lfsr;
  logic        q_ack[$];
  logic [1:0]  q_sts[$];
  logic [31:0] q_data[$];

  ps_cpld_regs i_dut (
    .ctrlport_clk            (ctrlport_clk),
    .ctrlport_rst            (ctrlport_rst),
    .req_wr                  (req_wr),
    .req_rd                  (req_rd),
    .req_addr                (req_addr),
    .req_data                (req_data),
    .resp_ack                (resp_ack),
    .resp_status             (resp_status),
    .resp_data               (resp_data),
    .db_clk_enable           (db_clk_enable),
    .db_reset                (db_reset),
    .pll_ref_clk_enable      (pll_ref_clk_enable),
    .dio_direction_a         (dio_direction_a),
    .dio_direction_b         (dio_direction_b),
    .cmi_ready               (cmi_ready),
    .cmi_other_side_detected (cmi_other_side_detected)
  );

  initial begin
    ctrlport_clk = 1'b0;
    forever #2 ctrlport_clk = ~ctrlport_clk;
  end

  // --------------------
  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'hA3000000;
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // --------------------
  // expected response of one request, model updated for writes
  task automatic predict(input logic wr, input logic rd, input logic [19:0] addr,
                         input logic [31:0] data, output logic e_ack,
                         output logic [1:0] e_sts, output logic [31:0] e_data);
    pl_db_word_u w;
    w      = data;
    e_ack  = 1'b0;
    e_sts  = `CTRL_STS_OKAY;
    e_data = '0;
    if (addr[19:6] == base[19:6] && (wr || rd)) begin
      e_ack = 1'b1;
      if (wr) begin
        case (addr[5:0])
          6'h0C: m_scratch = data;
          6'h20: begin
            // clear flag checked last so it wins
            if (w.cmd.enable_clock_db0) m_clk_en[0] = 1'b1;
            if (w.cmd.disable_clock_db0) m_clk_en[0] = 1'b0;
            if (w.cmd.enable_clock_db1) m_clk_en[1] = 1'b1;
            if (w.cmd.disable_clock_db1) m_clk_en[1] = 1'b0;
            if (w.cmd.enable_pll_ref_clock) m_pll = 1'b1;
            if (w.cmd.disable_pll_ref_clock) m_pll = 1'b0;
            if (w.cmd.release_reset_db0) m_rst[0] = 1'b0;
            if (w.cmd.assert_reset_db0) m_rst[0] = 1'b1;
            if (w.cmd.release_reset_db1) m_rst[1] = 1'b0;
            if (w.cmd.assert_reset_db1) m_rst[1] = 1'b1;
          end
          6'h30: begin
            m_dio_a = data[11:0];
            m_dio_b = data[27:16];
          end
          6'h3C: m_cmi_ready = data[0];
          default: e_sts = `CTRL_STS_CMDERR;
        endcase
      end else begin
        case (addr[5:0])
          6'h00: e_data = 32'h0A522D27;
          6'h04: e_data = 32'h21060911;
          6'h08: e_data = 32'h21040100;
          6'h0C: e_data = m_scratch;
          6'h10: e_data = 32'hDEADBEEF;
          6'h20: e_data = {26'd0, m_rst, 1'b0, m_pll, m_clk_en};
          6'h30: e_data = {4'd0, m_dio_b, 4'd0, m_dio_a};
          6'h3C: e_data = {m_other, 30'd0, m_cmi_ready};
          default: e_sts = `CTRL_STS_CMDERR;
        endcase
      end
    end
  endtask

  // drive one request on the rising edge, queue what it should return
  task automatic drive(input logic wr, input logic rd, input logic [19:0] addr,
                       input logic [31:0] data);
    logic        e_ack;
    logic [1:0]  e_sts;
    logic [31:0] e_data;
    @(posedge ctrlport_clk);
    m_other = rand_bits(1) == 1;
    req_wr <= wr;
    req_rd <= rd;
    req_addr <= addr;
    req_data <= data;
    cmi_other_side_detected <= m_other;
    predict(wr, rd, addr, data, e_ack, e_sts, e_data);
    q_ack.push_back(e_ack);
    q_sts.push_back(e_sts);
    q_data.push_back(e_data);
  endtask

  task automatic idle();
    @(posedge ctrlport_clk);
    req_wr <= 1'b0;
    req_rd <= 1'b0;
  endtask

  // compare the current response with the oldest queued one
  task automatic compare_resp();
    logic        e_ack;
    logic [1:0]  e_sts;
    logic [31:0] e_data;
    e_ack  = q_ack.pop_front();
    e_sts  = q_sts.pop_front();
    e_data = q_data.pop_front();
    check(resp_ack == e_ack, $sformatf("ack %0b, expected %0b", resp_ack, e_ack));
    if (e_ack) begin
      check(resp_status == e_sts, $sformatf("status %0d, expected %0d", resp_status, e_sts));
      check(resp_data == e_data,
            $sformatf("data %h, expected %h", resp_data, e_data));
    end
  endtask

  // single request, ack waited for with a timeout
  task automatic single(input logic wr, input logic rd, input logic [19:0] addr,
                        input logic [31:0] data);
    int cycles;
    drive(wr, rd, addr, data);
    idle();
    cycles = 0;
    do begin
      @(negedge ctrlport_clk);
      cycles++;
    end while (!resp_ack && cycles < 5);
    if (q_ack[0]) begin
      check(resp_ack, "no ack for an in-window request within 5 cycles");
      check(cycles == 1, $sformatf("ack after %0d cycles, expected 1", cycles));
    end
    compare_resp();
  endtask

  task automatic compare_outputs();
    @(negedge ctrlport_clk);
    check(db_clk_enable == m_clk_en, "db_clk_enable differs from model");
    check(db_reset == m_rst, "db_reset differs from model");
    check(pll_ref_clk_enable == m_pll, "pll_ref_clk_enable differs from model");
    check(dio_direction_a == m_dio_a, "dio_direction_a differs from model");
    check(dio_direction_b == m_dio_b, "dio_direction_b differs from model");
    check(cmi_ready == m_cmi_ready, "cmi_ready differs from model");
  endtask

  // --------------------
  // back to back random requests, one ack per request in order
  task automatic burst(input int n);
    logic [1:0] kind;
    logic [19:0] addr;
    for (int i = 0; i < n; i++) begin
      kind = rand_bits(2);
      addr = base | 20'(rand_bits(6));
      // now and then leave the window
      if (kind == 2'd3) begin
        addr = addr + 20'h00040;
      end
      drive(kind[0], rand_bits(1) == 1, addr, rand_bits(32));
      if (i > 0) begin
        @(negedge ctrlport_clk);
        compare_resp();
      end
    end
    idle();
    @(negedge ctrlport_clk);
    compare_resp();
    @(negedge ctrlport_clk);
    check(!resp_ack, "ack still high after an idle cycle");
  endtask

  initial begin
    pl_db_word_u w;
    lfsr = 32'd24;
    ctrlport_rst = 1'b1;
    req_wr = 1'b0;
    req_rd = 1'b0;
    req_addr = '0;
    req_data = '0;
    cmi_other_side_detected = 1'b0;
    m_scratch = '0;
    m_clk_en = 2'b00;
    m_rst = 2'b11;
    m_pll = 1'b0;
    m_dio_a = '0;
    m_dio_b = '0;
    m_cmi_ready = 1'b0;
    m_other = 1'b0;
    repeat (4) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;

    // reset values and identity words
    compare_outputs();
    check(!resp_ack && resp_status == `CTRL_STS_OKAY, "response not idle after reset");
    single(1'b0, 1'b1, base | 20'h00, '0);
    single(1'b0, 1'b1, base | 20'h04, '0);
    single(1'b0, 1'b1, base | 20'h08, '0);
    single(1'b0, 1'b1, base | 20'h10, '0);
    single(1'b0, 1'b1, base | 20'h20, '0);

    // round trips
    for (int i = 0; i < 20; i++) begin
      single(1'b1, 1'b0, base | 20'h0C, rand_bits(32));
      single(1'b0, 1'b1, base | 20'h0C, '0);
      single(1'b1, 1'b0, base | 20'h30, rand_bits(32));
      single(1'b0, 1'b1, base | 20'h30, '0);
      single(1'b1, 1'b0, base | 20'h3C, rand_bits(32));
      single(1'b0, 1'b1, base | 20'h3C, '0);
      compare_outputs();
    end

    // pl daughterboard flags
    for (int i = 0; i < 40; i++) begin
      w = rand_bits(32);
      single(1'b1, 1'b0, base | 20'h20, w);
      compare_outputs();
      single(1'b0, 1'b1, base | 20'h20, '0);
    end

    // errors, serial offsets and other holes
    single(1'b0, 1'b1, base | 20'h14, '0);
    single(1'b1, 1'b0, base | 20'h18, rand_bits(32));
    single(1'b0, 1'b1, base | 20'h24, '0);
    single(1'b1, 1'b0, base | 20'h2C, rand_bits(32));
    single(1'b1, 1'b1, base | 20'h0C, rand_bits(32));
    for (int i = 0; i < 5; i++) begin
      single(1'b1, 1'b0, base | 20'(i * 4), rand_bits(32));
    end
    single(1'b1, 1'b0, base | 20'h10, rand_bits(32));
    single(1'b0, 1'b1, base | 20'h00, '0);
    single(1'b0, 1'b1, base | 20'h04, '0);
    single(1'b0, 1'b1, base | 20'h08, '0);
    single(1'b0, 1'b1, base | 20'h10, '0);
    single(1'b0, 1'b1, base + 20'h00040, '0);
    single(1'b1, 1'b0, base - 20'h00004, rand_bits(32));

    // timing under back to back traffic
    for (int i = 0; i < 10; i++) begin
      burst(12);
    end
    compare_outputs();

    $display("Test OK");
    $finish;
  end

endmodule

// File: source/ps_cpld_regs.sv
/* ps cpld ctrlport registers */

`timescale 1ns/1ns

`include "ps_cpld_cfg.svh"

module ps_cpld_regs #(
  parameter logic [`CTRLPORT_ADDR_W-1:0] base_address = `PS_CPLD_BASE_ADDR
) (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  // ctrlport request
  input  logic                        req_wr,
  input  logic                        req_rd,
  input  logic [`CTRLPORT_ADDR_W-1:0] req_addr,
  input  logic [`CTRLPORT_DATA_W-1:0] req_data,
  // ctrlport response
  output logic                        resp_ack,
  output logic [1:0]                  resp_status,
  output logic [`CTRLPORT_DATA_W-1:0] resp_data,
  // board control
  output logic [1:0]                  db_clk_enable,
  output logic [1:0]                  db_reset,
  output logic                        pll_ref_clk_enable,
  output logic [`DIO_DIRECTION_W-1:0] dio_direction_a,
  output logic [`DIO_DIRECTION_W-1:0] dio_direction_b,
  output logic                        cmi_ready,
  input  logic                        cmi_other_side_detected
);

  import ps_cpld_pkg::*;

  logic [`PS_CPLD_NUM_REGS-1:0] wr_sel;
  logic [`PS_CPLD_NUM_REGS-1:0] rd_sel;
  logic                         respond;
  logic                         cmd_err;
  logic [`CTRLPORT_DATA_W-1:0]  scratch;
  logic [`CTRLPORT_DATA_W-1:0]  cmi_status;
  pl_db_word_u                  pl_db_status;

  // --------------------
  // request side, combinational
  ctrlport_decoder #(
    .base_address (base_address)
  ) i_decoder (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .respond      (respond),
    .cmd_err      (cmd_err)
  );

  // register state, updated on the request edge
  board_ctrl_regs i_regs (
    .ctrlport_clk            (ctrlport_clk),
    .ctrlport_rst            (ctrlport_rst),
    .wr_sel                  (wr_sel),
    .req_data                (req_data),
    .cmi_other_side_detected (cmi_other_side_detected),
    .scratch                 (scratch),
    .db_clk_enable           (db_clk_enable),
    .db_reset                (db_reset),
    .pll_ref_clk_enable      (pll_ref_clk_enable),
    .dio_direction_a         (dio_direction_a),
    .dio_direction_b         (dio_direction_b),
    .cmi_ready               (cmi_ready),
    .pl_db_status            (pl_db_status),
    .cmi_status              (cmi_status)
  );

  // response side, one register stage
  ctrlport_responder i_responder (
    .ctrlport_clk    (ctrlport_clk),
    .ctrlport_rst    (ctrlport_rst),
    .respond         (respond),
    .cmd_err         (cmd_err),
    .rd_sel          (rd_sel),
    .scratch         (scratch),
    .pl_db_status    (pl_db_status),
    .dio_direction_a (dio_direction_a),
    .dio_direction_b (dio_direction_b),
    .cmi_status      (cmi_status),
    .resp_ack        (resp_ack),
    .resp_status     (resp_status),
    .resp_data       (resp_data)
  );

endmodule

// File: source/ctrlport_responder.sv
/* ctrlport response stage */

`timescale 1ns/1ns

`include "ps_cpld_cfg.svh"

module ctrlport_responder (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  logic                         respond,
  input  logic                         cmd_err,
  input  logic [`PS_CPLD_NUM_REGS-1:0] rd_sel,
  input  logic [`CTRLPORT_DATA_W-1:0]  scratch,
  input  ps_cpld_pkg::pl_db_word_u     pl_db_status,
  input  logic [`DIO_DIRECTION_W-1:0]  dio_direction_a,
  input  logic [`DIO_DIRECTION_W-1:0]  dio_direction_b,
  input  logic [`CTRLPORT_DATA_W-1:0]  cmi_status,
  output logic                         resp_ack,
  output logic [1:0]                   resp_status,
  output logic [`CTRLPORT_DATA_W-1:0]  resp_data
);

  logic [`CTRLPORT_DATA_W-1:0] dio_word;
  logic [`CTRLPORT_DATA_W-1:0] rd_word;

  // --------------------
  // dio fields at their bit positions
  // gaps between the fields read as zero
  always_comb begin
    dio_word = '0;
    dio_word[`DIO_DIRECTION_A_LSB +: `DIO_DIRECTION_W] = dio_direction_a;
    dio_word[`DIO_DIRECTION_B_LSB +: `DIO_DIRECTION_W] = dio_direction_b;
  end

  // --------------------
  // read mux
  // rd_sel is one-hot for a defined read, zero otherwise,
  // so writes and errors fall through to a zero word
  always_comb begin
    rd_word = '0;
    if (rd_sel[`REG_IDX_SIGNATURE]) begin
      rd_word = `PS_CPLD_SIGNATURE;
    end
    if (rd_sel[`REG_IDX_REVISION]) begin
      rd_word = `CPLD_REVISION;
    end
    if (rd_sel[`REG_IDX_OLDEST_REVISION]) begin
      rd_word = `OLDEST_CPLD_REVISION;
    end
    if (rd_sel[`REG_IDX_SCRATCH]) begin
      rd_word = scratch;
    end
    if (rd_sel[`REG_IDX_GIT_HASH]) begin
      rd_word = `PS_CPLD_GIT_HASH;
    end
    if (rd_sel[`REG_IDX_PL_DB]) begin
      // status view, write flags never read back
      rd_word = pl_db_status;
    end
    if (rd_sel[`REG_IDX_DIO_DIRECTION]) begin
      rd_word = dio_word;
    end
    if (rd_sel[`REG_IDX_CMI]) begin
      rd_word = cmi_status;
    end
  end

  // --------------------
  // response registers
  // one cycle after the request, no back-pressure
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack    <= 1'b0;
      resp_status <= `CTRL_STS_OKAY;
    end else begin
      // out-of-window requests never raise respond
      resp_ack    <= respond;
      resp_status <= cmd_err ? `CTRL_STS_CMDERR : `CTRL_STS_OKAY;
    end
  end

  // data only means something while ack is high
  always_ff @(posedge ctrlport_clk) begin
    resp_data <= rd_word;
  end

  // an error ack never carries register data
  a_err_data_zero: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    resp_ack && resp_status == `CTRL_STS_CMDERR |-> resp_data == '0);

endmodule

// File: source/board_ctrl_regs.sv
/* board control register state */

`timescale 1ns/1ns

`include "ps_cpld_cfg.svh"

module board_ctrl_regs (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  logic [`PS_CPLD_NUM_REGS-1:0] wr_sel,
  input  ps_cpld_pkg::pl_db_word_u     req_data,
  input  logic                         cmi_other_side_detected,
  output logic [`CTRLPORT_DATA_W-1:0]  scratch,
  output logic [1:0]                   db_clk_enable,
  output logic [1:0]                   db_reset,
  output logic                         pll_ref_clk_enable,
  output logic [`DIO_DIRECTION_W-1:0]  dio_direction_a,
  output logic [`DIO_DIRECTION_W-1:0]  dio_direction_b,
  output logic                         cmi_ready,
  output ps_cpld_pkg::pl_db_word_u     pl_db_status,
  output logic [`CTRLPORT_DATA_W-1:0]  cmi_status
);

  import ps_cpld_pkg::*;

  logic [`CTRLPORT_DATA_W-1:0] wr_word;
  pl_db_cmd_t                  cmd_flags;

  // raw word for the plain fields, command view for the pl db flags
  assign wr_word   = req_data;
  assign cmd_flags = req_data.cmd;

  // next value of one controlled bit
  // the winning flag forces win_value, the other flag its inverse
  function automatic logic pair_update(
    input logic cur,
    input logic win_flag,
    input logic win_value,
    input logic lose_flag
  );
    if (win_flag) begin
      return win_value;
    end
    if (lose_flag) begin
      return ~win_value;
    end
    return cur;
  endfunction

  // --------------------
  // scratch
  always_ff @(posedge ctrlport_clk) begin
    if (wr_sel[`REG_IDX_SCRATCH]) begin
      scratch <= wr_word;
    end
  end

  // --------------------
  // control state
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      // daughterboards come up with clocks off and held in reset
      db_clk_enable      <= 2'b00;
      db_reset           <= 2'b11;
      pll_ref_clk_enable <= 1'b0;
      dio_direction_a    <= '0;
      dio_direction_b    <= '0;
      cmi_ready          <= 1'b0;
    end else begin
      if (wr_sel[`REG_IDX_PL_DB]) begin
        // disable beats enable
        db_clk_enable[0] <= pair_update(db_clk_enable[0], cmd_flags.disable_clock_db0,
                                        1'b0, cmd_flags.enable_clock_db0);
        db_clk_enable[1] <= pair_update(db_clk_enable[1], cmd_flags.disable_clock_db1,
                                        1'b0, cmd_flags.enable_clock_db1);
        pll_ref_clk_enable <= pair_update(pll_ref_clk_enable,
                                          cmd_flags.disable_pll_ref_clock,
                                          1'b0, cmd_flags.enable_pll_ref_clock);
        // assert beats release
        db_reset[0] <= pair_update(db_reset[0], cmd_flags.assert_reset_db0,
                                   1'b1, cmd_flags.release_reset_db0);
        db_reset[1] <= pair_update(db_reset[1], cmd_flags.assert_reset_db1,
                                   1'b1, cmd_flags.release_reset_db1);
      end
      if (wr_sel[`REG_IDX_DIO_DIRECTION]) begin
        dio_direction_a <= wr_word[`DIO_DIRECTION_A_LSB +: `DIO_DIRECTION_W];
        dio_direction_b <= wr_word[`DIO_DIRECTION_B_LSB +: `DIO_DIRECTION_W];
      end
      if (wr_sel[`REG_IDX_CMI]) begin
        cmi_ready <= wr_word[`CMI_READY_BIT];
      end
    end
  end

  // --------------------
  // read views
  always_comb begin
    pl_db_status = '0;
    pl_db_status.status.db0_clock_enabled     = db_clk_enable[0];
    pl_db_status.status.db1_clock_enabled     = db_clk_enable[1];
    pl_db_status.status.pll_ref_clock_enabled = pll_ref_clk_enable;
    pl_db_status.status.db0_reset_asserted    = db_reset[0];
    pl_db_status.status.db1_reset_asserted    = db_reset[1];
  end

  // other-side input goes straight through, not latched
  always_comb begin
    cmi_status = '0;
    cmi_status[`CMI_READY_BIT]      = cmi_ready;
    cmi_status[`CMI_OTHER_SIDE_BIT] = cmi_other_side_detected;
  end

  // conflicting flags in one write, the overriding flag must show next cycle
  a_pl_db_override: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    wr_sel[`REG_IDX_PL_DB] |=>
      (!$past(cmd_flags.disable_clock_db0 && cmd_flags.enable_clock_db0) ||
       !db_clk_enable[0]) &&
      (!$past(cmd_flags.disable_clock_db1 && cmd_flags.enable_clock_db1) ||
       !db_clk_enable[1]) &&
      (!$past(cmd_flags.disable_pll_ref_clock && cmd_flags.enable_pll_ref_clock) ||
       !pll_ref_clk_enable) &&
      (!$past(cmd_flags.assert_reset_db0 && cmd_flags.release_reset_db0) ||
       db_reset[0]) &&
      (!$past(cmd_flags.assert_reset_db1 && cmd_flags.release_reset_db1) ||
       db_reset[1]));

endmodule

// File: source/ctrlport_decoder.sv
/* ctrlport address decoder */

`timescale 1ns/1ns

`include "ps_cpld_cfg.svh"

module ctrlport_decoder #(
  // must be aligned to the window size
  parameter logic [`CTRLPORT_ADDR_W-1:0] base_address = `PS_CPLD_BASE_ADDR
) (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  logic                         req_wr,
  input  logic                         req_rd,
  input  logic [`CTRLPORT_ADDR_W-1:0]  req_addr,
  output logic [`PS_CPLD_NUM_REGS-1:0] wr_sel,
  output logic [`PS_CPLD_NUM_REGS-1:0] rd_sel,
  output logic                         respond,
  output logic                         cmd_err
);

  localparam int offset_w = $clog2(`PS_CPLD_NUM_ADDRESSES);

  // registers that accept a write
  localparam logic [`PS_CPLD_NUM_REGS-1:0] writable_mask = `PS_CPLD_NUM_REGS'(
    (1 << `REG_IDX_SCRATCH) | (1 << `REG_IDX_PL_DB) |
    (1 << `REG_IDX_DIO_DIRECTION) | (1 << `REG_IDX_CMI));

  logic [offset_w-1:0]          offset;
  logic                         in_window;
  logic                         rd_access;
  logic [`PS_CPLD_NUM_REGS-1:0] hit;
  logic [`PS_CPLD_NUM_REGS-1:0] wr_hit;

  // --------------------
  // window check
  // upper bits against the base, lower bits are the offset
  assign in_window = req_addr[`CTRLPORT_ADDR_W-1:offset_w] ==
                     base_address[`CTRLPORT_ADDR_W-1:offset_w];
  assign offset    = req_addr[offset_w-1:0];

  // one match bit per defined register
  // former serial number offsets match nothing
  always_comb begin
    hit = '0;
    hit[`REG_IDX_SIGNATURE]       = offset == `OFFSET_SIGNATURE;
    hit[`REG_IDX_REVISION]        = offset == `OFFSET_REVISION;
    hit[`REG_IDX_OLDEST_REVISION] = offset == `OFFSET_OLDEST_REVISION;
    hit[`REG_IDX_SCRATCH]         = offset == `OFFSET_SCRATCH;
    hit[`REG_IDX_GIT_HASH]        = offset == `OFFSET_GIT_HASH;
    hit[`REG_IDX_PL_DB]           = offset == `OFFSET_PL_DB;
    hit[`REG_IDX_DIO_DIRECTION]   = offset == `OFFSET_DIO_DIRECTION;
    hit[`REG_IDX_CMI]             = offset == `OFFSET_CMI;
  end

  // --------------------
  // selects and response flags
  // write wins, a read in the same cycle is dropped
  assign rd_access = req_rd & ~req_wr;
  assign wr_hit    = hit & writable_mask;

  assign wr_sel  = (req_wr & in_window) ? wr_hit : '0;
  assign rd_sel  = (rd_access & in_window) ? hit : '0;
  assign respond = (req_wr | req_rd) & in_window;

  // undefined offset, or write to a read-only register
  assign cmd_err = respond & (req_wr ? ~|wr_hit : ~|hit);

  // at most one register touched, never both directions at once
  a_sel_onehot: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(wr_sel) && $onehot0(rd_sel) && !(|wr_sel && |rd_sel));

endmodule

// File: source/ps_cpld_pkg.sv
/* ps cpld register types */

package ps_cpld_pkg;

  // --------------------
  // pl daughterboard word, write side
  // each action has a set flag and a clear flag
  typedef struct packed {
    logic [9:0] reserved_31_22;
    // reset pair, assert wins
    logic       assert_reset_db1;
    logic       assert_reset_db0;
    logic [1:0] reserved_19_18;
    logic       release_reset_db1;
    logic       release_reset_db0;
    logic       reserved_15;
    // clock pairs, disable wins
    logic       disable_pll_ref_clock;
    logic       disable_clock_db1;
    logic       disable_clock_db0;
    logic       reserved_11;
    logic       enable_pll_ref_clock;
    logic       enable_clock_db1;
    logic       enable_clock_db0;
    logic [7:0] reserved_7_0;
  } pl_db_cmd_t;

  // --------------------
  // pl daughterboard word, read side
  // reserved bits read back as zero
  typedef struct packed {
    logic [25:0] reserved_31_6;
    logic        db1_reset_asserted;
    logic        db0_reset_asserted;
    logic        reserved_3;
    logic        pll_ref_clock_enabled;
    logic        db1_clock_enabled;
    logic        db0_clock_enabled;
  } pl_db_status_t;

  // same 32-bit register, decoded per direction
  // writes go through cmd, reads through status
  typedef union packed {
    pl_db_cmd_t    cmd;
    pl_db_status_t status;
  } pl_db_word_u;

endpackage

// File: source/ps_cpld_cfg.svh
/* ps cpld register map configuration */

`ifndef PS_CPLD_CFG_SVH
`define PS_CPLD_CFG_SVH

// --------------------
// ctrlport geometry
`define PS_CPLD_BASE_ADDR      20'h00400
`define PS_CPLD_NUM_ADDRESSES  64
`define CTRLPORT_ADDR_W        20
`define CTRLPORT_DATA_W        32

// --------------------
// register indices, bit positions in the select vectors
`define REG_IDX_SIGNATURE        0
`define REG_IDX_REVISION         1
`define REG_IDX_OLDEST_REVISION  2
`define REG_IDX_SCRATCH          3
`define REG_IDX_GIT_HASH         4
`define REG_IDX_PL_DB            5
`define REG_IDX_DIO_DIRECTION    6
`define REG_IDX_CMI              7
`define PS_CPLD_NUM_REGS         8

// --------------------
// byte offsets from the base address
`define OFFSET_SIGNATURE        'h00
`define OFFSET_REVISION         'h04
`define OFFSET_OLDEST_REVISION  'h08
`define OFFSET_SCRATCH          'h0C
`define OFFSET_GIT_HASH         'h10
`define OFFSET_PL_DB            'h20
`define OFFSET_DIO_DIRECTION    'h30
`define OFFSET_CMI              'h3C

// response status codes
`define CTRL_STS_OKAY    2'd0
`define CTRL_STS_CMDERR  2'd1

// dio direction fields
`define DIO_DIRECTION_W      12
`define DIO_DIRECTION_A_LSB  0
`define DIO_DIRECTION_B_LSB  16

// cmi control/status bits
`define CMI_READY_BIT       0
`define CMI_OTHER_SIDE_BIT  31

// identity words, fixed at build
`define PS_CPLD_SIGNATURE     32'h0A522D27
`define CPLD_REVISION         32'h21060911
`define OLDEST_CPLD_REVISION  32'h21040100
`define PS_CPLD_GIT_HASH      32'hDEADBEEF

`endif
